// ==== common/ddr3_axi_defs.svh ====
`ifndef DDR3_AXI_DEFS_SVH
`define DDR3_AXI_DEFS_SVH

// Bus geometry
`define DDR3_ADDR_W     32                 // Byte address
`define DDR3_DATA_W     32                 // Full bus width
`define DDR3_MASK_W     (`DDR3_DATA_W / 8) // One strobe per byte lane

// Identifiers
`define DDR3_AXI_ID_W   4                  // AXI transaction ID
`define DDR3_TAG_W      4                  // Arrival-order tag to the controller

// Beats per memory command, the only burst length accepted
`define DDR3_BURST_LEN  4

// Buffer depths, powers of two
`define DDR3_CMD_DEPTH  4                  // AW, AR and B queues
`define DDR3_DATA_DEPTH 16                 // Write beats, read beats, read IDs

`endif

// ==== common/axi_pkg.sv ====
`include "ddr3_axi_defs.svh"

package axi_pkg;

  typedef logic [`DDR3_AXI_ID_W-1:0] axi_id_t;

  // AxBURST encoding, only INCR reaches the controller
  typedef enum logic [1:0] {
    AXI_BURST_FIXED = 2'b00,
    AXI_BURST_INCR  = 2'b01,
    AXI_BURST_WRAP  = 2'b10
  } axi_burst_t;

  // BRESP and RRESP encoding
  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_t;

  // Write request as held in the AW queue
  typedef struct packed {
    axi_id_t                 id;    // Returned later on B
    logic [`DDR3_ADDR_W-1:0] addr;  // Raw AWADDR, aligned on the way out
  } axi_aw_t;

endpackage

// ==== common/mem_pkg.sv ====
`include "ddr3_axi_defs.svh"

package mem_pkg;

  typedef logic [`DDR3_TAG_W-1:0]  mem_tag_t;
  typedef logic [`DDR3_ADDR_W-1:0] mem_addr_t;
  typedef logic [`DDR3_MASK_W-1:0] mem_mask_t;

  // One beat towards the controller datapath
  typedef struct packed {
    logic [`DDR3_DATA_W-1:0] data;
    mem_mask_t               mask;  // Byte enables from WSTRB
    logic                    last;  // Fourth beat of the burst
  } mem_wbeat_t;

  // One beat back from the controller datapath
  typedef struct packed {
    logic [`DDR3_DATA_W-1:0] data;
    logic                    last;
  } mem_rbeat_t;

endpackage

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4           // Power of two
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int ABITS = $clog2(DEPTH);
  localparam logic [ABITS:0] FULL_COUNT = (ABITS + 1)'(DEPTH);

  payload_t         mem [DEPTH];  // Storage flops, no reset
  logic [ABITS-1:0] wr_ptr;
  logic [ABITS-1:0] rd_ptr;
  logic [ABITS:0]   count;        // Entries held
  logic             push_fire;
  logic             pop_fire;

  assign push_ready_o = (count != FULL_COUNT);  // Stall while full
  assign pop_valid_o  = (count != '0);
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  // Head comes straight from the storage registers
  assign pop_data_o = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is 2^n
      if (pop_fire)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push_fire) mem[wr_ptr] <= push_data_i;  // Visible one cycle later
  end

endmodule

// ==== wr_path/axi_wr_path.sv ====
`timescale 1ns/1ps
`include "ddr3_axi_defs.svh"

module axi_wr_path import axi_pkg::*, mem_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    axi_awvalid_i,  // AW
  output logic                    axi_awready_o,
  input  axi_id_t                 axi_awid_i,
  input  logic [`DDR3_ADDR_W-1:0] axi_awaddr_i,
  input  logic                    axi_wvalid_i,   // W
  output logic                    axi_wready_o,
  input  logic [`DDR3_DATA_W-1:0] axi_wdata_i,
  input  logic [`DDR3_MASK_W-1:0] axi_wstrb_i,
  input  logic                    axi_wlast_i,
  output logic                    axi_bvalid_o,   // B
  input  logic                    axi_bready_i,
  output axi_id_t                 axi_bid_o,
  output axi_resp_t               axi_bresp_o,

  input  mem_tag_t                tag_i,          // Current order tag
  output logic                    mem_wrreq_o,
  input  logic                    mem_wrack_i,
  input  logic                    mem_wrerr_i,
  output mem_tag_t                mem_wrtid_o,
  output mem_addr_t               mem_wradr_o,
  output logic                    wr_issue_o,     // Command taken this cycle

  output logic                    mem_valid_o,    // Write beats
  input  logic                    mem_ready_i,
  output logic                    mem_wlast_o,
  output mem_mask_t               mem_wmask_o,
  output logic [`DDR3_DATA_W-1:0] mem_wdata_o
);

  localparam int        BURST_BYTES = `DDR3_BURST_LEN * `DDR3_MASK_W;
  localparam mem_addr_t BURST_MASK  = mem_addr_t'(BURST_BYTES - 1);

  // Pending response, ID kept locally and never sent to the controller
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_entry_t;

  axi_aw_t    aw_in;
  axi_aw_t    aw_head;
  logic       aw_pending;
  mem_wbeat_t w_in;
  mem_wbeat_t w_head;
  b_entry_t   b_in;
  b_entry_t   b_head;
  logic       b_room;

  assign aw_in.id   = axi_awid_i;
  assign aw_in.addr = axi_awaddr_i;

  sync_fifo #(
    .payload_t (axi_aw_t),
    .DEPTH     (`DDR3_CMD_DEPTH)
  ) aw_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (axi_awvalid_i),
    .push_ready_o (axi_awready_o),
    .push_data_i  (aw_in),
    .pop_valid_o  (aw_pending),
    .pop_ready_i  (wr_issue_o),  // Retire on acknowledge
    .pop_data_o   (aw_head)
  );

  // No new request without a free B slot, so a raised request never drops
  assign mem_wrreq_o = aw_pending & b_room;
  assign wr_issue_o  = mem_wrreq_o & mem_wrack_i;
  assign mem_wrtid_o = tag_i;
  assign mem_wradr_o = aw_head.addr & ~BURST_MASK;  // Whole-burst alignment

  // Error is sampled together with the acknowledge
  assign b_in.id   = aw_head.id;
  assign b_in.resp = mem_wrerr_i ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

  sync_fifo #(
    .payload_t (b_entry_t),
    .DEPTH     (`DDR3_CMD_DEPTH)
  ) b_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (wr_issue_o),
    .push_ready_o (b_room),
    .push_data_i  (b_in),
    .pop_valid_o  (axi_bvalid_o),  // Acknowledge order
    .pop_ready_i  (axi_bready_i),
    .pop_data_o   (b_head)
  );

  assign axi_bid_o   = b_head.id;
  assign axi_bresp_o = b_head.resp;

  // Write beats run on their own handshake
  assign w_in.data = axi_wdata_i;
  assign w_in.mask = axi_wstrb_i;
  assign w_in.last = axi_wlast_i;

  sync_fifo #(
    .payload_t (mem_wbeat_t),
    .DEPTH     (`DDR3_DATA_DEPTH)
  ) w_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (axi_wvalid_i),
    .push_ready_o (axi_wready_o),
    .push_data_i  (w_in),
    .pop_valid_o  (mem_valid_o),
    .pop_ready_i  (mem_ready_i),
    .pop_data_o   (w_head)
  );

  assign mem_wdata_o = w_head.data;
  assign mem_wmask_o = w_head.mask;
  assign mem_wlast_o = w_head.last;

endmodule

// ==== rd_path/axi_rd_path.sv ====
`timescale 1ns/1ps
`include "ddr3_axi_defs.svh"

module axi_rd_path import axi_pkg::*, mem_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    axi_arvalid_i,  // AR, ID handled above
  output logic                    axi_arready_o,
  input  logic [`DDR3_ADDR_W-1:0] axi_araddr_i,
  output logic                    axi_rvalid_o,   // R
  input  logic                    axi_rready_i,
  output logic [`DDR3_DATA_W-1:0] axi_rdata_o,
  output logic                    axi_rlast_o,
  output axi_resp_t               axi_rresp_o,

  input  mem_tag_t                tag_i,          // Tag after grant order
  output logic                    mem_rdreq_o,
  input  logic                    mem_rdack_i,
  output mem_tag_t                mem_rdtid_o,
  output mem_addr_t               mem_rdadr_o,
  output logic                    rd_issue_o,

  input  logic                    mem_valid_i,    // Read beats
  output logic                    mem_ready_o,
  input  logic                    mem_rlast_i,
  input  logic [`DDR3_DATA_W-1:0] mem_rdata_i
);

  localparam int        BURST_BYTES = `DDR3_BURST_LEN * `DDR3_MASK_W;
  localparam mem_addr_t BURST_MASK  = mem_addr_t'(BURST_BYTES - 1);

  mem_addr_t  ar_head;
  mem_rbeat_t r_in;
  mem_rbeat_t r_head;

  // Read requests, address only
  sync_fifo #(
    .payload_t (mem_addr_t),
    .DEPTH     (`DDR3_CMD_DEPTH)
  ) ar_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (axi_arvalid_i),
    .push_ready_o (axi_arready_o),
    .push_data_i  (axi_araddr_i),
    .pop_valid_o  (mem_rdreq_o),  // Held until acknowledged
    .pop_ready_i  (mem_rdack_i),
    .pop_data_o   (ar_head)
  );

  assign rd_issue_o  = mem_rdreq_o & mem_rdack_i;
  assign mem_rdtid_o = tag_i;
  assign mem_rdadr_o = ar_head & ~BURST_MASK;  // Burst aligned

  // Return data, fills up while R is stalled
  assign r_in.data = mem_rdata_i;
  assign r_in.last = mem_rlast_i;

  sync_fifo #(
    .payload_t (mem_rbeat_t),
    .DEPTH     (`DDR3_DATA_DEPTH)
  ) r_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (mem_valid_i),
    .push_ready_o (mem_ready_o),  // Drops when full
    .push_data_i  (r_in),
    .pop_valid_o  (axi_rvalid_o),
    .pop_ready_i  (axi_rready_i),
    .pop_data_o   (r_head)
  );

  assign axi_rdata_o = r_head.data;
  assign axi_rlast_o = r_head.last;
  assign axi_rresp_o = AXI_RESP_OKAY;  // No read errors from the controller

endmodule

// ==== logic/ddr3_axi_ctrl.sv ====
`timescale 1ns/1ps
`include "ddr3_axi_defs.svh"

module ddr3_axi_ctrl import axi_pkg::*, mem_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    axi_awvalid_i,
  output logic                    axi_awready_o,
  input  axi_id_t                 axi_awid_i,
  input  logic [`DDR3_ADDR_W-1:0] axi_awaddr_i,
  input  logic                    axi_wvalid_i,
  output logic                    axi_wready_o,
  input  logic [`DDR3_DATA_W-1:0] axi_wdata_i,
  input  logic [`DDR3_MASK_W-1:0] axi_wstrb_i,
  input  logic                    axi_wlast_i,
  output logic                    axi_bvalid_o,
  input  logic                    axi_bready_i,
  output axi_id_t                 axi_bid_o,
  output axi_resp_t               axi_bresp_o,

  input  logic                    axi_arvalid_i,
  output logic                    axi_arready_o,
  input  axi_id_t                 axi_arid_i,
  input  logic [`DDR3_ADDR_W-1:0] axi_araddr_i,
  output logic                    axi_rvalid_o,
  input  logic                    axi_rready_i,
  output axi_id_t                 axi_rid_o,
  output logic [`DDR3_DATA_W-1:0] axi_rdata_o,
  output logic                    axi_rlast_o,
  output axi_resp_t               axi_rresp_o,

  output logic                    mem_wrreq_o,    // Write command
  input  logic                    mem_wrack_i,
  input  logic                    mem_wrerr_i,
  output mem_tag_t                mem_wrtid_o,
  output mem_addr_t               mem_wradr_o,
  output logic                    mem_valid_o,    // Write data
  input  logic                    mem_ready_i,
  output logic                    mem_wlast_o,
  output mem_mask_t               mem_wmask_o,
  output logic [`DDR3_DATA_W-1:0] mem_wdata_o,

  output logic                    mem_rdreq_o,    // Read command
  input  logic                    mem_rdack_i,
  output mem_tag_t                mem_rdtid_o,
  output mem_addr_t               mem_rdadr_o,
  input  logic                    mem_valid_i,    // Read data
  output logic                    mem_ready_o,
  input  logic                    mem_rlast_i,
  input  logic [`DDR3_DATA_W-1:0] mem_rdata_i
);

  mem_tag_t req_tag;    // Next arrival-order tag
  mem_tag_t rd_tag;
  logic     wr_issue;
  logic     rd_issue;
  logic     rd_finish;

  // Write goes first when both are granted together
  assign rd_tag    = req_tag + mem_tag_t'(wr_issue);
  assign rd_finish = axi_rvalid_o & axi_rready_i & axi_rlast_o;  // Burst done

  always_ff @(posedge clock) begin
    if (reset) begin
      req_tag <= '0;
    end else begin
      req_tag <= req_tag + mem_tag_t'(wr_issue) + mem_tag_t'(rd_issue);  // Wraps at 16
    end
  end

  axi_wr_path wr_path_i (
    .clock         (clock),
    .reset         (reset),
    .axi_awvalid_i (axi_awvalid_i),
    .axi_awready_o (axi_awready_o),
    .axi_awid_i    (axi_awid_i),
    .axi_awaddr_i  (axi_awaddr_i),
    .axi_wvalid_i  (axi_wvalid_i),
    .axi_wready_o  (axi_wready_o),
    .axi_wdata_i   (axi_wdata_i),
    .axi_wstrb_i   (axi_wstrb_i),
    .axi_wlast_i   (axi_wlast_i),
    .axi_bvalid_o  (axi_bvalid_o),
    .axi_bready_i  (axi_bready_i),
    .axi_bid_o     (axi_bid_o),
    .axi_bresp_o   (axi_bresp_o),
    .tag_i         (req_tag),
    .mem_wrreq_o   (mem_wrreq_o),
    .mem_wrack_i   (mem_wrack_i),
    .mem_wrerr_i   (mem_wrerr_i),
    .mem_wrtid_o   (mem_wrtid_o),
    .mem_wradr_o   (mem_wradr_o),
    .wr_issue_o    (wr_issue),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .mem_wlast_o   (mem_wlast_o),
    .mem_wmask_o   (mem_wmask_o),
    .mem_wdata_o   (mem_wdata_o)
  );

  axi_rd_path rd_path_i (
    .clock         (clock),
    .reset         (reset),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_araddr_i  (axi_araddr_i),
    .axi_rvalid_o  (axi_rvalid_o),
    .axi_rready_i  (axi_rready_i),
    .axi_rdata_o   (axi_rdata_o),
    .axi_rlast_o   (axi_rlast_o),
    .axi_rresp_o   (axi_rresp_o),
    .tag_i         (rd_tag),
    .mem_rdreq_o   (mem_rdreq_o),
    .mem_rdack_i   (mem_rdack_i),
    .mem_rdtid_o   (mem_rdtid_o),
    .mem_rdadr_o   (mem_rdadr_o),
    .rd_issue_o    (rd_issue),
    .mem_valid_i   (mem_valid_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rlast_i   (mem_rlast_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  // AR IDs in controller accept order, matched to R bursts as they finish
  sync_fifo #(
    .payload_t (axi_id_t),
    .DEPTH     (`DDR3_DATA_DEPTH)
  ) rd_id_fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (rd_issue),
    .push_ready_o (),
    .push_data_i  (axi_arid_i),
    .pop_valid_o  (),
    .pop_ready_i  (rd_finish),
    .pop_data_o   (axi_rid_o)
  );

endmodule

// ==== dv/ddr3_axi_ctrl_props.sv ====
`timescale 1ns/1ps

module ddr3_axi_ctrl_props (
  input logic        clock,
  input logic        reset,
  input logic        axi_bvalid_o,
  input logic        axi_bready_i,
  input logic [3:0]  axi_bid_o,
  input logic        axi_rvalid_o,
  input logic        axi_rready_i,
  input logic [31:0] axi_rdata_o,
  input logic        mem_valid_o,
  input logic        mem_ready_i,
  input logic [31:0] mem_wdata_o,
  input logic        mem_wrreq_o,
  input logic        mem_wrack_i,
  input logic        mem_rdreq_o,
  input logic        mem_rdack_i
);

  // Outputs hold while stalled
  b_stable_a : assert property (@(posedge clock) disable iff (reset)
    axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o && $stable(axi_bid_o))
    else $error("B valid or ID changed under stall");
  r_stable_a : assert property (@(posedge clock) disable iff (reset)
    axi_rvalid_o && !axi_rready_i |=> axi_rvalid_o && $stable(axi_rdata_o))
    else $error("R valid or data changed under stall");
  w_stable_a : assert property (@(posedge clock) disable iff (reset)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_wdata_o))
    else $error("Write beat changed under stall");

  // Requests wait for the acknowledge
  wrreq_hold_a : assert property (@(posedge clock) disable iff (reset)
    mem_wrreq_o && !mem_wrack_i |=> mem_wrreq_o)
    else $error("Write request dropped before acknowledge");
  rdreq_hold_a : assert property (@(posedge clock) disable iff (reset)
    mem_rdreq_o && !mem_rdack_i |=> mem_rdreq_o)
    else $error("Read request dropped before acknowledge");

  reset_idle_a : assert property (@(posedge clock) reset |=> !mem_valid_o)
    else $error("Write beat valid right after reset");

endmodule

bind ddr3_axi_ctrl ddr3_axi_ctrl_props props_i (.*);

// ==== dv/ddr3_axi_ctrl_tb.sv ====
`timescale 1ns/1ps

module ddr3_axi_ctrl_tb;

  localparam int NUM_BURSTS = 40;
  localparam int TIMEOUT    = NUM_BURSTS * 40;  // Cycles for the whole run

  logic        clock, reset;
  logic        axi_awvalid_i, axi_awready_o, axi_wvalid_i, axi_wready_o, axi_wlast_i;
  logic [3:0]  axi_awid_i, axi_wstrb_i, axi_bid_o, axi_arid_i, axi_rid_o;
  logic [31:0] axi_awaddr_i, axi_wdata_i, axi_araddr_i, axi_rdata_o;
  logic        axi_bvalid_o, axi_bready_i, axi_arvalid_i, axi_arready_o;
  logic        axi_rvalid_o, axi_rready_i, axi_rlast_o;
  logic [1:0]  axi_bresp_o, axi_rresp_o;
  logic        mem_wrreq_o, mem_wrack_i, mem_wrerr_i, mem_rdreq_o, mem_rdack_i;
  logic [3:0]  mem_wrtid_o, mem_rdtid_o, mem_wmask_o;
  logic [31:0] mem_wradr_o, mem_rdadr_o, mem_wdata_o, mem_rdata_i;
  logic        mem_valid_o, mem_ready_i, mem_wlast_o;
  logic        mem_valid_i, mem_ready_o, mem_rlast_i;

  logic [7:0]  ref_mem [256];   // Scoreboard view
  logic [7:0]  ctrl_mem [256];  // Controller model storage
  logic [36:0] wbeat_q [$];     // {data, mask, last}
  logic [32:0] rbeat_q [$];     // {data, last}
  logic [5:0]  exp_b_q [$];     // {id, resp}
  logic [3:0]  exp_tag;
  logic [3:0]  cur_id;
  int          wr_wait, rd_wait, cycles;
  logic        stall;
  logic        wr_busy, rd_busy;            // Burst in flight per stream
  logic [7:0]  wr_busy_addr, rd_busy_addr;  // Base of that burst
  int          num_wr, num_rd;              // Split of the random mix

  ddr3_axi_ctrl ddr3_axi_ctrl_i (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("timeout, run still busy after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] ref_word(logic [7:0] addr);
    return {ref_mem[addr + 8'd3], ref_mem[addr + 8'd2], ref_mem[addr + 8'd1], ref_mem[addr]};
  endfunction

  task automatic write_burst(logic [3:0] id, logic [7:0] addr);
    logic [5:0] exp_b;
    cur_id = id;
    @(posedge clock); #1;
    axi_awvalid_i = 1'b1;
    axi_awid_i    = id;
    axi_awaddr_i  = {24'd0, addr};
    do @(negedge clock); while (!axi_awready_o);
    @(posedge clock); #1;
    axi_awvalid_i = 1'b0;
    for (int b = 0; b < 4; b++) begin
      axi_wvalid_i = 1'b1;
      axi_wdata_i  = $urandom;
      axi_wstrb_i  = 4'($urandom);
      axi_wlast_i  = (b == 3);
      for (int k = 0; k < 4; k++)
        if (axi_wstrb_i[k]) ref_mem[addr + 8'(4 * b + k)] = axi_wdata_i[8 * k +: 8];
      do @(negedge clock); while (!axi_wready_o);
      @(posedge clock); #1;
      axi_wvalid_i = 1'b0;
    end
    do @(negedge clock); while (!(axi_bvalid_o && axi_bready_i));
    assert (exp_b_q.size() > 0) else begin
      $display("B response came out with no acknowledged write behind it");
      abort_run();
    end
    exp_b = exp_b_q.pop_front();
    check_value("bid", exp_b[5:2], axi_bid_o);
    check_value("bresp", exp_b[1:0], axi_bresp_o);
  endtask

  task automatic read_burst(logic [3:0] id, logic [7:0] addr);
    @(posedge clock); #1;
    axi_arvalid_i = 1'b1;
    axi_arid_i    = id;  // Kept until the burst returns
    axi_araddr_i  = {24'd0, addr};
    do @(negedge clock); while (!axi_arready_o);
    @(posedge clock); #1;
    axi_arvalid_i = 1'b0;
    for (int b = 0; b < 4; b++) begin
      do @(negedge clock); while (!(axi_rvalid_o && axi_rready_i));
      check_value("rid", id, axi_rid_o);
      check_value("rresp", 2'b00, axi_rresp_o);
      check_value("rdata", ref_word(addr + 8'(4 * b)), axi_rdata_o);
      check_value("rlast", b == 3, axi_rlast_o);
    end
  endtask

  // Writes skip the burst that is being read
  task automatic write_stream();
    logic [7:0] addr;
    for (int n = 0; n < num_wr; n++) begin
      do addr = 8'(($urandom % 16) * 16); while (rd_busy && addr == rd_busy_addr);
      wr_busy      = 1'b1;
      wr_busy_addr = addr;
      write_burst(4'($urandom), addr);
      wr_busy = 1'b0;
    end
  endtask

  // Reads skip the burst that is being written
  task automatic read_stream();
    logic [7:0] addr;
    for (int n = 0; n < num_rd; n++) begin
      do addr = 8'(($urandom % 16) * 16); while (wr_busy && addr == wr_busy_addr);
      rd_busy      = 1'b1;
      rd_busy_addr = addr;
      read_burst(4'($urandom), addr);
      rd_busy = 1'b0;
    end
  endtask

  // Controller command side with tags checked in accept order
  initial begin
    logic        wr_fire, rd_fire;
    logic [36:0] beat;
    forever begin
      @(negedge clock);
      wr_fire = !reset && mem_wrreq_o && mem_wrack_i;
      rd_fire = !reset && mem_rdreq_o && mem_rdack_i;
      if (wr_fire) begin
        check_value("wr_tag", exp_tag, mem_wrtid_o);
        check_value("wr_addr", axi_awaddr_i & ~32'hf, mem_wradr_o);
        for (int b = 0; b < 4; b++) begin
          beat = wbeat_q.pop_front();
          check_value("wlast", b == 3, beat[0]);
          for (int k = 0; k < 4; k++)
            if (beat[1 + k]) ctrl_mem[8'(mem_wradr_o) + 8'(4 * b + k)] = beat[5 + 8 * k +: 8];
        end
        exp_b_q.push_back({cur_id, mem_wrerr_i ? 2'b10 : 2'b00});
        exp_tag++;
      end
      if (rd_fire) begin
        check_value("rd_tag", exp_tag, mem_rdtid_o);
        check_value("rd_addr", axi_araddr_i & ~32'hf, mem_rdadr_o);
        for (int b = 0; b < 4; b++)
          rbeat_q.push_back({ctrl_mem[8'(mem_rdadr_o) + 8'(4 * b + 3)],
                             ctrl_mem[8'(mem_rdadr_o) + 8'(4 * b + 2)],
                             ctrl_mem[8'(mem_rdadr_o) + 8'(4 * b + 1)],
                             ctrl_mem[8'(mem_rdadr_o) + 8'(4 * b)], b == 3});
        exp_tag++;
      end
      @(posedge clock); #1;
      if (wr_fire) begin
        mem_wrack_i = 1'b0;
        mem_wrerr_i = 1'b0;
        wr_wait     = $urandom % 4;
      end else if (mem_wrreq_o && wbeat_q.size() >= 4) begin  // Whole burst in hand
        if (wr_wait == 0) begin
          mem_wrack_i = 1'b1;
          mem_wrerr_i = ($urandom % 8 == 0);
        end else wr_wait--;
      end
      if (rd_fire) begin
        mem_rdack_i = 1'b0;
        rd_wait     = $urandom % 4;
      end else if (mem_rdreq_o) begin
        if (rd_wait == 0) mem_rdack_i = 1'b1;
        else rd_wait--;
      end
    end
  end

  // Write beat sink and read beat source
  initial begin
    forever begin
      @(negedge clock);
      if (!reset && mem_valid_o && mem_ready_i)
        wbeat_q.push_back({mem_wdata_o, mem_wmask_o, mem_wlast_o});
      if (!reset && mem_valid_i && mem_ready_o) void'(rbeat_q.pop_front());
      @(posedge clock); #1;
      mem_ready_i = ($urandom % 4 != 0);
      mem_valid_i = (rbeat_q.size() > 0) && ($urandom % 4 != 0);
      if (mem_valid_i) {mem_rdata_i, mem_rlast_i} = rbeat_q[0];
    end
  end

  // Response back-pressure with long stalls
  initial begin
    forever begin
      @(posedge clock); #1;
      if ($urandom % 12 == 0) stall = !stall;
      axi_bready_i = !stall && ($urandom % 4 != 0);
      axi_rready_i = !stall && ($urandom % 4 != 0);
    end
  end

  initial begin
    void'($urandom(32'hf4130f20));
    clock         = 1'b0;
    reset         = 1'b1;
    cycles        = 0;
    stall         = 1'b0;
    exp_tag       = '0;
    wr_wait       = 0;
    rd_wait       = 0;
    cur_id        = '0;
    wr_busy       = 1'b0;
    rd_busy       = 1'b0;
    wr_busy_addr  = '0;
    rd_busy_addr  = '0;
    num_wr        = 0;
    num_rd        = 0;
    axi_awvalid_i = 0;
    axi_awid_i    = 0;
    axi_awaddr_i  = 0;
    axi_wvalid_i  = 0;
    axi_wdata_i   = 0;
    axi_wstrb_i   = 0;
    axi_wlast_i   = 0;
    axi_bready_i  = 0;
    axi_arvalid_i = 0;
    axi_arid_i    = 0;
    axi_araddr_i  = 0;
    axi_rready_i  = 0;
    mem_wrack_i   = 0;
    mem_wrerr_i   = 0;
    mem_rdack_i   = 0;
    mem_ready_i   = 0;
    mem_valid_i   = 0;
    mem_rlast_i   = 0;
    mem_rdata_i   = 0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a]  = 8'(a) ^ 8'h5a;  // Same fill on both sides
      ctrl_mem[a] = 8'(a) ^ 8'h5a;
    end
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    check_value("idle_bvalid", 0, axi_bvalid_o);
    check_value("idle_rvalid", 0, axi_rvalid_o);
    check_value("idle_wrreq", 0, mem_wrreq_o);
    check_value("idle_rdreq", 0, mem_rdreq_o);
    check_value("idle_mem_valid", 0, mem_valid_o);
    for (int n = 0; n < NUM_BURSTS; n++) begin
      if ($urandom % 2) num_wr++;
      else num_rd++;
    end
    // Both streams at once so acknowledges can meet in one cycle
    fork
      write_stream();
      read_stream();
    join
    repeat (20) @(negedge clock);
    assert (!axi_bvalid_o && !axi_rvalid_o && exp_b_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("responses left over after the last burst");
      abort_run();
    end
  end

endmodule

// ==== vlog.f ====
+incdir+common
common/axi_pkg.sv
common/mem_pkg.sv
logic/sync_fifo.sv
wr_path/axi_wr_path.sv
rd_path/axi_rd_path.sv
logic/ddr3_axi_ctrl.sv
dv/ddr3_axi_ctrl_props.sv
dv/ddr3_axi_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module ddr3_axi_ctrl_tb -o sim &&
./obj_dir/sim | grep "NO ERRORS" &&
echo "PASS" || { echo "FAIL"; exit 1; }
